// File: Makefile
# Verilator build and run of the bfloat16 matrix multiplier testbench

SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := matrix_float_multiplier_tb
FILELIST := matrix_float_multiplier.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: float_multiplier.sv
/*
 * Two stage bfloat16 multiplier
 * Stage 1 forms sign, biased exponent sum and mantissa product
 * Stage 2 normalizes, truncates and applies zero and infinity rules
 * Valid and both tags ride along with the data
 */

`timescale 1ns/1ps

module float_multiplier import matrix_float_pkg::*; (
  input  logic  CLK,
  input  logic  RST,
  input  logic  mul_valid,
  input  logic  mul_row_end,
  input  logic  mul_matrix_end,
  input  elem_t mul_a,
  input  elem_t mul_b,
  output logic  prod_valid,
  output logic  prod_row_end,
  output logic  prod_matrix_end,
  output elem_t prod_data
);

  ////////////////////////////////////////
  // Stage 1 registers
  ////////////////////////////////////////

  logic               s1_valid;
  logic               s1_row_end;
  logic               s1_matrix_end;
  logic               s1_sign;
  logic signed [9:0]  s1_exp;
  logic [15:0]        s1_mant;
  logic               s1_zero;

  // Stage 2 combinational result
  logic signed [9:0]  exp_norm;
  logic [6:0]         frac_norm;
  elem_t              result;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= mul_valid;
    end
  end

  always_ff @(posedge CLK) begin
    s1_row_end    <= mul_row_end;
    s1_matrix_end <= mul_matrix_end;
    s1_sign       <= mul_a[15] ^ mul_b[15];
    // Both exponents zero extended, bias taken off once
    s1_exp  <= $signed({2'b00, mul_a[14:7]}) + $signed({2'b00, mul_b[14:7]}) - EXP_BIAS;
    // Hidden ones restored before the 8x8 product
    s1_mant <= {1'b1, mul_a[6:0]} * {1'b1, mul_b[6:0]};
    // Zero exponent on either side flushes the result
    s1_zero <= (mul_a[14:7] == 8'd0) || (mul_b[14:7] == 8'd0);
  end

  ////////////////////////////////////////
  // Stage 2 normalize and round off
  ////////////////////////////////////////

  always_comb begin
    // Product in [1,4), top bit set means one extra binade
    if (s1_mant[15]) begin
      exp_norm  = s1_exp + 10'sd1;
      frac_norm = s1_mant[14:8];
    end else begin
      exp_norm  = s1_exp;
      frac_norm = s1_mant[13:7];
    end
    if (s1_zero || exp_norm <= 10'sd0) begin
      result = {s1_sign, 15'd0};
    end else if (exp_norm >= EXP_INF) begin
      result = {s1_sign, 8'hFF, 7'd0};
    end else begin
      result = {s1_sign, exp_norm[7:0], frac_norm};
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      prod_valid <= 1'b0;
    end else begin
      prod_valid <= s1_valid;
    end
  end

  always_ff @(posedge CLK) begin
    prod_data       <= result;
    prod_row_end    <= s1_row_end;
    prod_matrix_end <= s1_matrix_end;
  end

endmodule

// File: matrix_element_producer.sv
/*
 * Matrix element producer
 * Takes the start and operand pairs, walks the i and j indices,
 * tags row and matrix ends and spends one credit per pair
 */

`timescale 1ns/1ps

module matrix_element_producer import matrix_float_pkg::*; (
  input  logic  CLK,
  input  logic  RST,
  input  logic  start,
  input  dim_t  size_i,
  input  dim_t  size_j,
  input  logic  in_valid,
  input  elem_t in_a,
  input  elem_t in_b,
  output logic  in_ready,
  output logic  busy,
  input  logic  credit_return,
  output logic  mul_valid,
  output logic  mul_row_end,
  output logic  mul_matrix_end,
  output elem_t mul_a,
  output elem_t mul_b
);

  prod_state_t state;
  dim_t        size_i_q;
  dim_t        size_j_q;
  dim_t        index_i;
  dim_t        index_j;
  credit_t     credits;
  logic        accept;
  logic        last_j;
  logic        last_i;

  // Room downstream only while credits remain
  assign in_ready = (state == PROD_STREAM) && (credits != credit_t'(0));
  assign accept   = in_valid && in_ready;

  assign last_j = (index_j == size_j_q - dim_t'(1));
  assign last_i = (index_i == size_i_q - dim_t'(1));

  ////////////////////////////////////////
  // Index FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= PROD_IDLE;
      busy     <= 1'b0;
      size_i_q <= '0;
      size_j_q <= '0;
      index_i  <= '0;
      index_j  <= '0;
    end else begin
      case (state)
        PROD_IDLE: begin
          // Zero sized matrix is not a job
          if (start && size_i != '0 && size_j != '0) begin
            size_i_q <= size_i;
            size_j_q <= size_j;
            index_i  <= '0;
            index_j  <= '0;
            busy     <= 1'b1;
            state    <= PROD_STREAM;
          end
        end
        PROD_STREAM: begin
          // Start is ignored here
          if (accept) begin
            if (last_j) begin
              index_j <= '0;
              index_i <= index_i + dim_t'(1);
              if (last_i) begin
                busy  <= 1'b0;
                state <= PROD_IDLE;
              end
            end else begin
              index_j <= index_j + dim_t'(1);
            end
          end
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Credits and multiplier feed
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      credits   <= credit_t'(FIFO_DEPTH);
      mul_valid <= 1'b0;
    end else begin
      mul_valid <= accept;
      // Spend and return in one cycle cancel out
      case ({accept, credit_return})
        2'b10:   credits <= credits - credit_t'(1);
        2'b01:   credits <= credits + credit_t'(1);
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      mul_a          <= in_a;
      mul_b          <= in_b;
      mul_row_end    <= last_j;
      mul_matrix_end <= last_j && last_i;
    end
  end

endmodule

// File: matrix_float_multiplier.f
+incdir+.
matrix_float_pkg.sv
float_multiplier.sv
matrix_element_producer.sv
product_credit_fifo.sv
matrix_result_consumer.sv
matrix_float_multiplier_top.sv
matrix_float_multiplier_tb.sv

// File: tb_float_model.svh
/*
 * Testbench reference model
 * Linear congruential random source and a bfloat16 multiply
 * with truncation, flush to zero and overflow to infinity
 */

`ifndef TB_FLOAT_MODEL_SVH
`define TB_FLOAT_MODEL_SVH

// Random state, fixed seed
int unsigned rng_state = 32'd81;

// Next 16 bit random value, upper half of the LCG state
function automatic int unsigned rand_next();
  rng_state = rng_state * 32'd1664525 + 32'd1013904223;
  return rng_state >> 16;
endfunction

// bfloat16 product worked out on plain integers
function automatic elem_t bf16_mul_ref(input elem_t a, input elem_t b);
  int    exp_a;
  int    exp_b;
  int    exp_r;
  int    mant_p;
  int    frac_r;
  logic  sign_r;
  elem_t res;
  sign_r = a[15] ^ b[15];
  exp_a  = int'(a[14:7]);
  exp_b  = int'(b[14:7]);
  // Hidden ones give significands 128..255
  mant_p = (128 + int'(a[6:0])) * (128 + int'(b[6:0]));
  exp_r  = exp_a + exp_b - 127;
  // Product lies in [1,4) scaled by 2^14
  if (mant_p >= 32768) begin
    exp_r  = exp_r + 1;
    frac_r = mant_p / 256 - 128;
  end else begin
    frac_r = mant_p / 128 - 128;
  end
  if (exp_a == 0 || exp_b == 0 || exp_r <= 0) begin
    res = {sign_r, 15'd0};
  end else if (exp_r >= 255) begin
    res = {sign_r, 8'hFF, 7'd0};
  end else begin
    res = {sign_r, exp_r[7:0], frac_r[6:0]};
  end
  return res;
endfunction

`endif

// File: matrix_float_multiplier_tb.sv
/*
 * Testbench for the element-wise bfloat16 matrix multiplier
 * Random operands from a fixed seed, a queue of expected
 * products and tags, an output monitor and per test reports
 */

`timescale 1ns/1ps

module matrix_float_multiplier_tb import matrix_float_pkg::*; ();

  `include "tb_float_model.svh"

  // DUT ports
  logic  CLK;
  logic  RST;
  logic  start;
  dim_t  size_i;
  dim_t  size_j;
  logic  in_valid;
  elem_t in_a;
  elem_t in_b;
  logic  in_ready;
  logic  busy;
  logic  out_ready;
  logic  out_valid;
  elem_t out_data;
  logic  out_row_end;
  logic  out_matrix_end;

  // Expected entries {row_end, matrix_end, data}
  logic [17:0] exp_q [$];
  logic [17:0] front;

  // Operands of the matrix being sent
  elem_t a_buf [225];
  elem_t b_buf [225];

  string       test_name;
  int          errors;
  int          errors_at_start;
  int          tests_run;
  int          tests_failed;
  int          results_seen;
  int          ready_low_cycles;
  int unsigned ready_pct;
  int unsigned cycle_limit;

  matrix_float_multiplier_top u_matrix_float_multiplier_top (
    .CLK            (CLK),
    .RST            (RST),
    .start          (start),
    .size_i         (size_i),
    .size_j         (size_j),
    .in_valid       (in_valid),
    .in_a           (in_a),
    .in_b           (in_b),
    .in_ready       (in_ready),
    .busy           (busy),
    .out_ready      (out_ready),
    .out_valid      (out_valid),
    .out_data       (out_data),
    .out_row_end    (out_row_end),
    .out_matrix_end (out_matrix_end)
  );

  // 4 ns clock
  initial CLK = 1'b0;
  always #2 CLK = ~CLK;

  ////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////

  task automatic report_mismatch(input string field, input logic [15:0] exp_v,
                                 input logic [15:0] act_v);
    $display("Fail %s %s expected %h actual %h", test_name, field, exp_v, act_v);
    errors++;
  endtask

  // Output transfers happen on the rising edge
  always @(posedge CLK) begin
    if (!RST && out_valid && out_ready) begin
      results_seen++;
      if (exp_q.size() == 0) begin
        $display("Result %h arrived in test %s with none outstanding", out_data, test_name);
        errors++;
      end else begin
        front = exp_q.pop_front();
        if (out_data !== front[15:0])
          report_mismatch("data", front[15:0], out_data);
        if (out_row_end !== front[17])
          report_mismatch("row_end", {15'd0, front[17]}, {15'd0, out_row_end});
        if (out_matrix_end !== front[16])
          report_mismatch("matrix_end", {15'd0, front[16]}, {15'd0, out_matrix_end});
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  task automatic timeout_abort(input string what);
    $display("Timeout in test %s while waiting for %s", test_name, what);
    $display("SOME TESTS FAILED");
    $finish;
  endtask

  // Advance to the falling edge and draw a new out_ready
  task automatic next_cycle();
    @(negedge CLK);
    if (ready_pct >= 100)
      out_ready = 1'b1;
    else
      out_ready = (rand_next() % 100) < ready_pct;
  endtask

  // Exponent kept in 1..254 so no NaN or infinity
  function automatic elem_t rand_elem();
    int unsigned r;
    int unsigned e;
    r = rand_next();
    e = rand_next() % 254;
    return {r[0], e[7:0] + 8'd1, r[7:1]};
  endfunction

  task automatic fill_random(input int unsigned n);
    int unsigned k;
    for (k = 0; k < n; k++) begin
      a_buf[k] = rand_elem();
      b_buf[k] = rand_elem();
    end
  endtask

  // Stores one hand picked pair and checks the model on it
  task automatic load_special_pair(input int idx, input elem_t a, input elem_t b,
                                   input elem_t expected);
    a_buf[idx] = a;
    b_buf[idx] = b;
    if (bf16_mul_ref(a, b) !== expected)
      report_mismatch("model", expected, bf16_mul_ref(a, b));
  endtask

  // Sampled by the producer on the next rising edge
  task automatic start_matrix(input dim_t ni, input dim_t nj);
    start  = 1'b1;
    size_i = ni;
    size_j = nj;
    next_cycle();
    start  = 1'b0;
  endtask

  // Row-major pairs with in_valid drawn each cycle
  task automatic stream_pairs(input int unsigned ni, input int unsigned nj,
                              input int unsigned valid_pct);
    int unsigned k;
    int unsigned waited;
    logic        accepted;
    logic [17:0] entry;
    for (k = 0; k < ni * nj; k++) begin
      entry = {((k % nj) == nj - 1), (k == ni * nj - 1), bf16_mul_ref(a_buf[k], b_buf[k])};
      in_a     = a_buf[k];
      in_b     = b_buf[k];
      accepted = 1'b0;
      waited   = 0;
      while (!accepted) begin
        in_valid = (rand_next() % 100) < valid_pct;
        @(posedge CLK);
        if (!in_ready)
          ready_low_cycles++;
        if (in_valid && in_ready) begin
          accepted = 1'b1;
          exp_q.push_back(entry);
        end else begin
          waited++;
          if (waited > cycle_limit)
            timeout_abort("an input pair to be accepted");
        end
        next_cycle();
      end
    end
    in_valid = 1'b0;
  endtask

  // Until every accepted pair has come out
  task automatic wait_drain();
    int unsigned waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      next_cycle();
      waited++;
      if (waited > cycle_limit)
        timeout_abort("the outstanding results");
    end
    ready_pct = 100;
    next_cycle();
  endtask

  task automatic begin_test(input string name);
    test_name        = name;
    errors_at_start  = errors;
    results_seen     = 0;
    ready_low_cycles = 0;
  endtask

  task automatic end_test(input int expected);
    if (results_seen != expected) begin
      $display("Fail %s result count expected %0d actual %0d",
               test_name, expected, results_seen);
      errors++;
    end
    tests_run++;
    if (errors == errors_at_start) begin
      $display("Test %s ok, %0d results", test_name, results_seen);
    end else begin
      tests_failed++;
      $display("Test %s failed, %0d errors", test_name, errors - errors_at_start);
    end
  endtask

  task automatic check_busy(input logic expected, input string when);
    if (busy !== expected) begin
      $display("Fail %s busy %s expected %b actual %b", test_name, when, expected, busy);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    RST          = 1'b1;
    start        = 1'b0;
    size_i       = '0;
    size_j       = '0;
    in_valid     = 1'b0;
    in_a         = '0;
    in_b         = '0;
    out_ready    = 1'b1;
    ready_pct    = 100;
    cycle_limit  = 5000;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (10) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    next_cycle();

    // Single element carries both tags
    begin_test("single_1x1");
    fill_random(1);
    start_matrix(4'd1, 4'd1);
    stream_pairs(1, 1, 100);
    wait_drain();
    end_test(1);

    begin_test("random_3x4");
    fill_random(12);
    start_matrix(4'd3, 4'd4);
    stream_pairs(3, 4, 100);
    wait_drain();
    end_test(12);

    // Signed zero, infinities, underflow and the exponent 0/1 edge
    begin_test("special_values");
    load_special_pair(0, 16'h802B, 16'h3FC0, 16'h8000);
    load_special_pair(1, 16'h3F80, 16'h0000, 16'h0000);
    load_special_pair(2, 16'h6400, 16'h6400, 16'h7F80);
    load_special_pair(3, 16'hE400, 16'h6400, 16'hFF80);
    load_special_pair(4, 16'h0A00, 16'h8F00, 16'h8000);
    load_special_pair(5, 16'h3FC0, 16'h3FC0, 16'h4010);
    load_special_pair(6, 16'h1FC0, 16'h2040, 16'h0090);
    load_special_pair(7, 16'h1F80, 16'h2000, 16'h0000);
    start_matrix(4'd2, 4'd4);
    stream_pairs(2, 4, 100);
    wait_drain();
    end_test(8);

    // Output stalls fill the FIFO and use up the credits
    begin_test("backpressure_15x15");
    fill_random(225);
    ready_pct = 40;
    start_matrix(4'd15, 4'd15);
    stream_pairs(15, 15, 70);
    wait_drain();
    if (ready_low_cycles == 0) begin
      $display("in_ready never dropped while the output stalled in test %s", test_name);
      errors++;
    end
    end_test(225);

    begin_test("start_handling");
    start_matrix(4'd0, 4'd3);
    check_busy(1'b0, "after a start with a zero size");
    next_cycle();
    check_busy(1'b0, "a cycle after a start with a zero size");
    fill_random(4);
    start_matrix(4'd2, 4'd2);
    check_busy(1'b1, "after a valid start");
    // Second start mid stream must not change the 2x2 tags
    start_matrix(4'd7, 4'd7);
    stream_pairs(2, 2, 100);
    wait_drain();
    check_busy(1'b0, "after out_matrix_end");
    fill_random(3);
    start_matrix(4'd1, 4'd3);
    stream_pairs(1, 3, 100);
    wait_drain();
    check_busy(1'b0, "after the follow-up matrix");
    end_test(7);

    $display("Summary %0d tests run, %0d failed, %0d errors",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: matrix_float_multiplier_top.sv
/*
 * Element-wise bfloat16 matrix multiplier
 * Producer, two stage multiplier, product FIFO and consumer
 * with credit based flow control inside
 */

`timescale 1ns/1ps

module matrix_float_multiplier_top import matrix_float_pkg::*; (
  input  logic  CLK,
  input  logic  RST,
  input  logic  start,
  input  dim_t  size_i,
  input  dim_t  size_j,
  input  logic  in_valid,
  input  elem_t in_a,
  input  elem_t in_b,
  output logic  in_ready,
  output logic  busy,
  input  logic  out_ready,
  output logic  out_valid,
  output elem_t out_data,
  output logic  out_row_end,
  output logic  out_matrix_end
);

  ////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////

  // Producer to multiplier
  logic  mul_valid;
  logic  mul_row_end;
  logic  mul_matrix_end;
  elem_t mul_a;
  elem_t mul_b;

  // Multiplier to FIFO
  logic  prod_valid;
  logic  prod_row_end;
  logic  prod_matrix_end;
  elem_t prod_data;

  // FIFO to consumer, credits back
  logic  fifo_empty;
  elem_t fifo_data;
  logic  fifo_row_end;
  logic  fifo_matrix_end;
  logic  fifo_pop;
  logic  credit_return;

  matrix_element_producer u_producer (
    .CLK            (CLK),
    .RST            (RST),
    .start          (start),
    .size_i         (size_i),
    .size_j         (size_j),
    .in_valid       (in_valid),
    .in_a           (in_a),
    .in_b           (in_b),
    .in_ready       (in_ready),
    .busy           (busy),
    .credit_return  (credit_return),
    .mul_valid      (mul_valid),
    .mul_row_end    (mul_row_end),
    .mul_matrix_end (mul_matrix_end),
    .mul_a          (mul_a),
    .mul_b          (mul_b)
  );

  float_multiplier u_multiplier (
    .CLK             (CLK),
    .RST             (RST),
    .mul_valid       (mul_valid),
    .mul_row_end     (mul_row_end),
    .mul_matrix_end  (mul_matrix_end),
    .mul_a           (mul_a),
    .mul_b           (mul_b),
    .prod_valid      (prod_valid),
    .prod_row_end    (prod_row_end),
    .prod_matrix_end (prod_matrix_end),
    .prod_data       (prod_data)
  );

  product_credit_fifo u_fifo (
    .CLK             (CLK),
    .RST             (RST),
    .prod_valid      (prod_valid),
    .prod_row_end    (prod_row_end),
    .prod_matrix_end (prod_matrix_end),
    .prod_data       (prod_data),
    .fifo_pop        (fifo_pop),
    .fifo_empty      (fifo_empty),
    .fifo_data       (fifo_data),
    .fifo_row_end    (fifo_row_end),
    .fifo_matrix_end (fifo_matrix_end)
  );

  matrix_result_consumer u_consumer (
    .CLK             (CLK),
    .RST             (RST),
    .fifo_empty      (fifo_empty),
    .fifo_data       (fifo_data),
    .fifo_row_end    (fifo_row_end),
    .fifo_matrix_end (fifo_matrix_end),
    .fifo_pop        (fifo_pop),
    .credit_return   (credit_return),
    .out_ready       (out_ready),
    .out_valid       (out_valid),
    .out_data        (out_data),
    .out_row_end     (out_row_end),
    .out_matrix_end  (out_matrix_end)
  );

endmodule

// File: matrix_float_pkg.sv
/*
 * Matrix float multiplier shared definitions
 * Element and dimension types, FIFO sizing, credit width,
 * producer FSM states and bfloat16 exponent constants
 */

package matrix_float_pkg;

  ////////////////////////////////////////
  // Data types
  ////////////////////////////////////////

  // One bfloat16 element
  // Sign bit 15, exponent bits 14..7, fraction bits 6..0
  typedef logic [15:0] elem_t;

  // Matrix dimension or running index, 1 to 15
  typedef logic [3:0] dim_t;

  ////////////////////////////////////////
  // Buffering and flow control
  ////////////////////////////////////////

  // FIFO slots, also the starting credit count
  localparam int FIFO_DEPTH = 4;

  // Credit counter, holds 0 to FIFO_DEPTH
  typedef logic [2:0] credit_t;

  // Read and write pointers into the FIFO
  typedef logic [1:0] fifo_ptr_t;

  // Producer FSM
  typedef enum logic {
    PROD_IDLE,
    PROD_STREAM
  } prod_state_t;

  ////////////////////////////////////////
  // Floating point constants
  ////////////////////////////////////////

  // Bias and saturating exponent in the signed working width
  localparam logic signed [9:0] EXP_BIAS = 10'sd127;
  localparam logic signed [9:0] EXP_INF  = 10'sd255;

endpackage

// File: matrix_result_consumer.sv
/*
 * Result consumer
 * Pops the FIFO into a valid/ready output register
 * and hands one credit back per pop
 */

`timescale 1ns/1ps

module matrix_result_consumer import matrix_float_pkg::*; (
  input  logic  CLK,
  input  logic  RST,
  input  logic  fifo_empty,
  input  elem_t fifo_data,
  input  logic  fifo_row_end,
  input  logic  fifo_matrix_end,
  output logic  fifo_pop,
  output logic  credit_return,
  input  logic  out_ready,
  output logic  out_valid,
  output elem_t out_data,
  output logic  out_row_end,
  output logic  out_matrix_end
);

  ////////////////////////////////////////
  // Pop decision
  ////////////////////////////////////////

  // Register free, or its value leaves this cycle
  assign fifo_pop = !fifo_empty && (!out_valid || out_ready);

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_valid     <= 1'b0;
      credit_return <= 1'b0;
    end else begin
      // One credit per popped slot, a cycle later
      credit_return <= fifo_pop;
      if (fifo_pop) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  // Data holds steady while out_ready is low
  always_ff @(posedge CLK) begin
    if (fifo_pop) begin
      out_data       <= fifo_data;
      out_row_end    <= fifo_row_end;
      out_matrix_end <= fifo_matrix_end;
    end
  end

endmodule

// File: product_credit_fifo.sv
/*
 * Product FIFO
 * Circular buffer of products with row and matrix tags
 * Credits upstream keep it from overflowing
 */

`timescale 1ns/1ps

module product_credit_fifo import matrix_float_pkg::*; (
  input  logic  CLK,
  input  logic  RST,
  input  logic  prod_valid,
  input  logic  prod_row_end,
  input  logic  prod_matrix_end,
  input  elem_t prod_data,
  input  logic  fifo_pop,
  output logic  fifo_empty,
  output elem_t fifo_data,
  output logic  fifo_row_end,
  output logic  fifo_matrix_end
);

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  // Entry layout {row_end, matrix_end, data}
  logic [17:0] mem [FIFO_DEPTH];

  fifo_ptr_t wr_ptr;
  fifo_ptr_t rd_ptr;
  logic [$clog2(FIFO_DEPTH):0] count;

  always_ff @(posedge CLK) begin
    if (prod_valid) begin
      mem[wr_ptr] <= {prod_row_end, prod_matrix_end, prod_data};
    end
  end

  ////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap on their own at depth 4
      if (prod_valid) begin
        wr_ptr <= wr_ptr + fifo_ptr_t'(1);
      end
      if (fifo_pop) begin
        rd_ptr <= rd_ptr + fifo_ptr_t'(1);
      end
      case ({prod_valid, fifo_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head entry shown ahead of the pop
  assign fifo_empty      = (count == '0);
  assign fifo_data       = mem[rd_ptr][15:0];
  assign fifo_matrix_end = mem[rd_ptr][16];
  assign fifo_row_end    = mem[rd_ptr][17];

endmodule
